// File: Bender.yml
package:
  name: panel

sources:
  - include_dirs:
      - src
    files:
      - src/panel_input_pkg.sv
      - src/panel_ctrl_pkg.sv
      - src/button_conditioner.sv
      - src/mode_controller.sv
      - src/led_driver.sv
      - src/panel_top.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - bench/panel_assertions.sv
      - bench/panel_checker.sv
      - bench/panel_tb.sv

// File: bench/panel_assertions.sv
module panel_assertions
	import panel_ctrl_pkg::*;
(
	input logic  clk,
	input logic  reset,
	input mode_t mode,
	input logic  mode_changed,
	input logic  status_led
);

	int failures = 0;

	// The step strobe is a single cycle wide.
	strobe_one_cycle: assert property (@(posedge clk) disable iff (reset)
		mode_changed |=> !mode_changed)
		else begin
			failures++;
			$error("mode_changed stayed high for more than one cycle");
		end

	// Mode and strobe come from the same press, so they move together.
	mode_moves_on_press: assert property (@(posedge clk) disable iff (reset)
		!$stable(mode) |-> mode_changed)
		else begin
			failures++;
			$error("mode changed without a press");
		end

	// One cycle after entering OFF the LED has caught up.
	dark_in_off: assert property (@(posedge clk) disable iff (reset)
		(mode == MODE_OFF && !mode_changed) |-> !status_led)
		else begin
			failures++;
			$error("status_led lit in MODE_OFF");
		end

endmodule

bind led_driver panel_assertions u_led_assertions (
	.clk          (clk),
	.reset        (reset),
	.mode         (mode),
	.mode_changed (mode_changed),
	.status_led   (status_led)
);

// File: bench/panel_checker.sv
`include "panel_params.svh"

module panel_checker
	import panel_input_pkg::*;
	import panel_ctrl_pkg::*;
(
	input  logic          clk,
	input  logic          reset,
	input  logic          mode_btn_raw,
	input  logic          ping_btn_raw,
	input  panel_status_t status,
	input  buttons_t      buttons,
	output int            mismatches
);

	// Index 0 is the mode button and index 1 the ping button.
	logic [`SYNC_DELAY_LEN-1:0] sync_q [2];
	logic  cand [2];
	logic  clean [2];
	logic  clean_prev [2];
	int    db_cnt [2];
	mode_t mode;
	logic  mode_changed;
	int    tick_cnt;
	int    blink_cnt;
	logic  status_led;
	logic  act_led;
	int    ext_cnt;

	initial begin
		mismatches = 0;
		sync_q[0] = '0;
		sync_q[1] = '0;
	end

	function automatic mode_t next_mode(input mode_t m);
		case (m)
			MODE_OFF: return MODE_ON;
			MODE_ON: return MODE_BLINK;
			default: return MODE_OFF;
		endcase
	endfunction

	// All next values are taken from the state before this edge.
	always @(posedge clk) begin : model_step
		logic mode_press;
		logic ping_press;
		logic blink_done;
		logic synced;
		logic raw_in;
		mode_press = clean[0] & ~clean_prev[0];
		ping_press = clean[1] & ~clean_prev[1];
		blink_done = (tick_cnt == 0) && (blink_cnt == `BLINK_TICKS - 1);
		if (reset) begin
			status_led = 1'b0;
			act_led = 1'b0;
			ext_cnt = 0;
			blink_cnt = 0;
		end else begin
			if (mode != MODE_BLINK || mode_changed || blink_done) begin
				blink_cnt = 0;
			end else if (tick_cnt == 0) begin
				blink_cnt++;
			end
			case (mode)
				MODE_ON: status_led = 1'b1;
				MODE_BLINK: status_led = mode_changed ? 1'b0 : status_led ^ blink_done;
				default: status_led = 1'b0;
			endcase
			if (ping_press) begin
				act_led = 1'b1;
				ext_cnt = 0;
			end else if (ext_cnt == `EXTEND_LEN) begin
				act_led = 1'b0;
			end else begin
				ext_cnt++;
			end
		end
		tick_cnt = (reset || tick_cnt == `TICK_PERIOD - 1) ? 0 : tick_cnt + 1;
		mode_changed = !reset && mode_press;
		if (reset) begin
			mode = MODE_OFF;
		end else if (mode_press) begin
			mode = next_mode(mode);
		end
		for (int b = 0; b < 2; b++) begin
			synced = sync_q[b][0];
			raw_in = (b == 0) ? mode_btn_raw : ping_btn_raw;
			if (reset) begin
				cand[b] = synced;
				clean[b] = synced;
				clean_prev[b] = synced;
				db_cnt[b] = 0;
			end else begin
				clean_prev[b] = clean[b];
				if (synced != cand[b]) begin
					cand[b] = synced;
					db_cnt[b] = 0;
				end else if (db_cnt[b] == `DEBOUNCE_COUNT) begin
					clean[b] = cand[b];
				end else begin
					db_cnt[b]++;
				end
			end
			sync_q[b] = {raw_in, sync_q[b][`SYNC_DELAY_LEN-1:1]};
		end
	end

	task automatic compare_field(input string name, input logic [1:0] got,
			input logic [1:0] want);
		if (got !== want) begin
			$display("Mismatch at %0t: %s is %b, model expects %b", $time, name, got, want);
			mismatches++;
		end
	endtask

	// Outputs settle well before the falling edge.
	always @(negedge clk) begin
		if (reset === 1'b0) begin
			compare_field("status.mode", status.mode, mode);
			compare_field("status.status_led", status.status_led, status_led);
			compare_field("status.act_led", status.act_led, act_led);
			compare_field("buttons.mode_btn.level", buttons.mode_btn.level, clean[0]);
			compare_field("buttons.mode_btn.press", buttons.mode_btn.press,
				clean[0] & ~clean_prev[0]);
			compare_field("buttons.ping_btn.level", buttons.ping_btn.level, clean[1]);
			compare_field("buttons.ping_btn.press", buttons.ping_btn.press,
				clean[1] & ~clean_prev[1]);
		end
	end

endmodule

// File: bench/panel_tb.sv
`include "panel_params.svh"

module panel_tb
	import panel_input_pkg::*;
	import panel_ctrl_pkg::*;
();

	localparam int LEVEL_LATENCY = `SYNC_DELAY_LEN + `DEBOUNCE_COUNT + 2;
	localparam int BLINK_HALF = `TICK_PERIOD * `BLINK_TICKS;
	localparam int WAIT_LIMIT = 200;

	logic          clk;
	logic          reset;
	logic          mode_btn_raw;
	logic          ping_btn_raw;
	panel_status_t status;
	buttons_t      buttons;
	int            mismatches;
	int            tb_errors;
	int            tests_run;
	int            tests_failed;
	int            mode_presses;
	logic [31:0]   rand_state;
	mode_t         expected_mode;

	panel_top u_panel_top (
		.clk          (clk),
		.reset        (reset),
		.mode_btn_raw (mode_btn_raw),
		.ping_btn_raw (ping_btn_raw),
		.status       (status),
		.buttons      (buttons)
	);

	panel_checker u_checker (
		.clk          (clk),
		.reset        (reset),
		.mode_btn_raw (mode_btn_raw),
		.ping_btn_raw (ping_btn_raw),
		.status       (status),
		.buttons      (buttons),
		.mismatches   (mismatches)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(negedge clk) begin
		if (!reset && buttons.mode_btn.press) mode_presses++;
	end

	function automatic logic [31:0] next_random();
		rand_state = rand_state ^ (rand_state << 13);
		rand_state = rand_state ^ (rand_state >> 17);
		rand_state = rand_state ^ (rand_state << 5);
		return rand_state;
	endfunction

	function automatic mode_t mode_after(input mode_t m);
		if (m == MODE_OFF) return MODE_ON;
		if (m == MODE_ON) return MODE_BLINK;
		return MODE_OFF;
	endfunction

	function automatic int error_total();
		return mismatches + tb_errors + u_panel_top.u_leds.u_led_assertions.failures;
	endfunction

	task automatic step(input int cycles);
		repeat (cycles) begin
			@(posedge clk);
			#2;
		end
	endtask

	task automatic drive_button(input int which, input logic level);
		if (which == 0) mode_btn_raw = level;
		else ping_btn_raw = level;
	endtask

	task automatic press_button(input int which, input int hold, input int gap);
		drive_button(which, 1'b1);
		step(hold);
		drive_button(which, 1'b0);
		step(gap);
	endtask

	task automatic finish_test(input string name, input int errors_before);
		tests_run++;
		if (error_total() != errors_before) begin
			tests_failed++;
			$display("test %0d %s: failed", tests_run, name);
		end else begin
			$display("test %0d %s: passed", tests_run, name);
		end
	endtask

	task automatic wait_level(input int which, input logic value, output int cycles);
		cycles = 0;
		while ((which == 0 ? buttons.mode_btn.level : buttons.ping_btn.level) !== value
				&& cycles < WAIT_LIMIT) begin
			step(1);
			cycles++;
		end
		if (cycles == WAIT_LIMIT) begin
			$display("Timeout at %0t: button %0d level never reached %b", $time, which, value);
			tb_errors++;
		end
	endtask

	// Presses the mode button and checks the new mode and its LED.
	task automatic step_mode();
		mode_t from_mode;
		int n;
		from_mode = status.mode;
		expected_mode = mode_after(expected_mode);
		fork
			press_button(0, `DEBOUNCE_COUNT + 4 + (next_random() % 8), `DEBOUNCE_COUNT + 6);
			begin
				n = 0;
				while (status.mode == from_mode && n < WAIT_LIMIT) begin
					step(1);
					n++;
				end
				if (n == WAIT_LIMIT) begin
					$display("Timeout at %0t: mode never left %s", $time, from_mode.name());
					tb_errors++;
				end
				step(1);
				if (status.mode !== expected_mode ||
						status.status_led !== (expected_mode == MODE_ON)) begin
					$display("Mismatch at %0t: mode %s with status_led %b after a press",
						$time, status.mode.name(), status.status_led);
					tb_errors++;
				end
			end
		join
	endtask

	task automatic time_status_toggle(output int cycles);
		logic start;
		start = status.status_led;
		cycles = 0;
		while (status.status_led == start && cycles < WAIT_LIMIT) begin
			step(1);
			cycles++;
		end
		if (cycles == WAIT_LIMIT) begin
			$display("Timeout at %0t: status LED never toggled in BLINK", $time);
			tb_errors++;
		end
	endtask

	// Counts lit cycles from the last ping strobe until the LED goes dark.
	task automatic time_activity(output int lit);
		int n;
		n = 0;
		lit = 0;
		while (!buttons.ping_btn.press && n < WAIT_LIMIT) begin
			step(1);
			n++;
		end
		if (n == WAIT_LIMIT) begin
			$display("Timeout at %0t: ping press strobe never seen", $time);
			tb_errors++;
		end
		n = 0;
		do begin
			step(1);
			n++;
			if (buttons.ping_btn.press) lit = 0;
			else if (status.act_led) lit++;
		end while ((status.act_led || buttons.ping_btn.press) && n < WAIT_LIMIT);
		if (n == WAIT_LIMIT) begin
			$display("Timeout at %0t: act_led never went dark after the last ping", $time);
			tb_errors++;
		end
	endtask

	task automatic random_mix(input int cycles);
		int remaining [2];
		logic level [2];
		logic [31:0] r;
		remaining[0] = 0;
		remaining[1] = 0;
		level[0] = 1'b0;
		level[1] = 1'b0;
		for (int c = 0; c < cycles; c++) begin
			for (int b = 0; b < 2; b++) begin
				if (remaining[b] == 0) begin
					r = next_random();
					level[b] = ~level[b];
					if (r[3:0] < 5) remaining[b] = 1 + (r[31:8] % (`DEBOUNCE_COUNT - 1));
					else remaining[b] = `DEBOUNCE_COUNT + (r[31:8] % 40);
					drive_button(b, level[b]);
				end
				remaining[b]--;
			end
			step(1);
		end
		drive_button(0, 1'b0);
		drive_button(1, 1'b0);
		step(LEVEL_LATENCY + `EXTEND_LEN + 8);
	endtask

	initial begin : stimulus
		int errors_before;
		int presses_before;
		int n;
		int total;
		int glitch_hold;
		logic glitch_raised;
		reset = 1'b1;
		mode_btn_raw = 1'b0;
		ping_btn_raw = 1'b0;
		rand_state = 32'd79180;
		tb_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		mode_presses = 0;
		expected_mode = MODE_OFF;
		step(8);
		reset = 1'b0;
		step(2);

		errors_before = error_total();
		if (status.mode !== MODE_OFF || status.status_led !== 1'b0 ||
				status.act_led !== 1'b0 || buttons !== 4'b0) begin
			$display("Mismatch at %0t: reset state status %b buttons %b", $time, status, buttons);
			tb_errors++;
		end
		finish_test("reset state", errors_before);

		errors_before = error_total();
		presses_before = mode_presses;
		// The clean level must stay low through each glitch and the gap after it.
		repeat (6) begin
			glitch_hold = 1 + (next_random() % (`DEBOUNCE_COUNT - 1));
			glitch_raised = 1'b0;
			mode_btn_raw = 1'b1;
			for (int c = 0; c < glitch_hold + `DEBOUNCE_COUNT + 4; c++) begin
				if (c == glitch_hold) mode_btn_raw = 1'b0;
				step(1);
				if (buttons.mode_btn.level !== 1'b0) glitch_raised = 1'b1;
			end
			if (glitch_raised) begin
				$display("Mismatch at %0t: a short glitch raised the mode level", $time);
				tb_errors++;
			end
		end
		mode_btn_raw = 1'b1;
		wait_level(0, 1'b1, n);
		if (n != LEVEL_LATENCY) begin
			$display("Mismatch at %0t: level latency %0d, expected %0d", $time, n, LEVEL_LATENCY);
			tb_errors++;
		end
		step(4);
		mode_btn_raw = 1'b0;
		wait_level(0, 1'b0, n);
		expected_mode = mode_after(expected_mode);
		if (mode_presses != presses_before + 1) begin
			$display("Mismatch at %0t: %0d press strobes, expected 1", $time,
				mode_presses - presses_before);
			tb_errors++;
		end
		finish_test("debounce", errors_before);

		errors_before = error_total();
		repeat (6) step_mode();
		finish_test("mode cycling", errors_before);

		errors_before = error_total();
		while (expected_mode != MODE_BLINK) step_mode();
		time_status_toggle(n);
		repeat (3) begin
			time_status_toggle(n);
			if (n != BLINK_HALF) begin
				$display("Mismatch at %0t: blink half period %0d, expected %0d", $time, n,
					BLINK_HALF);
				tb_errors++;
			end
		end
		finish_test("blink timing", errors_before);

		errors_before = error_total();
		repeat (4) begin
			fork
				press_button(1, `DEBOUNCE_COUNT + 4 + (next_random() % 6), `DEBOUNCE_COUNT + 4);
				time_activity(n);
			join
			if (n != `EXTEND_LEN + 1) begin
				$display("Mismatch at %0t: act_led lit %0d cycles, expected %0d", $time, n,
					`EXTEND_LEN + 1);
				tb_errors++;
			end
		end
		finish_test("activity extension", errors_before);

		errors_before = error_total();
		random_mix(5000);
		finish_test("random mix", errors_before);

		total = error_total();
		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total);
		if (total == 0 && tests_failed == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

// File: sources.f
+incdir+src
src/panel_input_pkg.sv
src/panel_ctrl_pkg.sv
src/button_conditioner.sv
src/mode_controller.sv
src/led_driver.sv
src/panel_top.sv
bench/panel_assertions.sv
bench/panel_checker.sv
bench/panel_tb.sv

// File: src/button_conditioner.sv
`include "panel_params.svh"

module button_conditioner
	import panel_input_pkg::*;
(
	input  logic    clk,
	input  logic    reset,
	input  logic    raw,
	output button_t button
);

	localparam int SYNC_LEN = `SYNC_DELAY_LEN;
	localparam int DB_COUNT = `DEBOUNCE_COUNT;
	localparam int DB_WIDTH = $clog2(DB_COUNT + 1);
	localparam logic [DB_WIDTH-1:0] DB_LAST = DB_WIDTH'(DB_COUNT);

	logic [SYNC_LEN-1:0] sync_q;
	logic                synced;
	logic                candidate;
	logic [DB_WIDTH-1:0] db_count;
	logic                clean;
	logic                clean_prev;

	// Raw input enters at the top stage and leaves at bit 0.
	always_ff @(posedge clk) begin
		sync_q[SYNC_LEN-1] <= raw;
		for (int i = 0; i < SYNC_LEN - 1; i++) begin
			sync_q[i] <= sync_q[i+1];
		end
	end

	assign synced = sync_q[0];

	// Any change of the synchronized input restarts the count.
	// The clean level only moves once the candidate has held long enough.
	always_ff @(posedge clk) begin
		if (reset) begin
			candidate <= synced;
			clean <= synced;
			db_count <= '0;
		end else if (synced != candidate) begin
			candidate <= synced;
			db_count <= '0;
		end else if (db_count == DB_LAST) begin
			clean <= candidate;
		end else begin
			db_count <= db_count + 1'b1;
		end
	end

	// Previous clean level for the one-shot.
	always_ff @(posedge clk) begin
		if (reset) begin
			clean_prev <= synced;
		end else begin
			clean_prev <= clean;
		end
	end

	assign button.level = clean;

	// High in the first cycle of a high clean level only.
	assign button.press = clean & ~clean_prev;

endmodule

// File: src/led_driver.sv
`include "panel_params.svh"

module led_driver
	import panel_ctrl_pkg::*;
(
	input  logic  clk,
	input  logic  reset,
	input  mode_t mode,
	input  logic  mode_changed,
	input  logic  ping,
	output logic  status_led,
	output logic  act_led
);

	localparam int TICK_LEN = `TICK_PERIOD;
	localparam int BLINK_LEN = `BLINK_TICKS;
	localparam int EXT_LEN = `EXTEND_LEN;
	localparam int TICK_WIDTH = (TICK_LEN > 1) ? $clog2(TICK_LEN) : 1;
	localparam int BLINK_WIDTH = (BLINK_LEN > 1) ? $clog2(BLINK_LEN) : 1;
	localparam int EXT_WIDTH = $clog2(EXT_LEN + 1);
	localparam logic [TICK_WIDTH-1:0] TICK_LAST = TICK_WIDTH'(TICK_LEN - 1);
	localparam logic [BLINK_WIDTH-1:0] BLINK_LAST = BLINK_WIDTH'(BLINK_LEN - 1);
	localparam logic [EXT_WIDTH-1:0] EXT_LAST = EXT_WIDTH'(EXT_LEN);

	logic [TICK_WIDTH-1:0]  tick_count;
	logic                   tick;
	logic [BLINK_WIDTH-1:0] blink_count;
	logic                   blink_done;
	logic [EXT_WIDTH-1:0]   ext_count;

	// Free-running divider, one tick every TICK_LEN cycles.
	always_ff @(posedge clk) begin
		if (reset || tick_count == TICK_LAST) begin
			tick_count <= '0;
		end else begin
			tick_count <= tick_count + 1'b1;
		end
	end

	assign tick = (tick_count == '0);

	// Counts ticks within one blink half period.
	always_ff @(posedge clk) begin
		if (reset) begin
			blink_count <= '0;
		end else if (mode != MODE_BLINK || mode_changed) begin
			blink_count <= '0;
		end else if (tick) begin
			if (blink_done) begin
				blink_count <= '0;
			end else begin
				blink_count <= blink_count + 1'b1;
			end
		end
	end

	assign blink_done = tick && (blink_count == BLINK_LAST);

	// Status LED, with the blink phase cleared on every mode step.
	always_ff @(posedge clk) begin
		if (reset) begin
			status_led <= 1'b0;
		end else begin
			case (mode)
				MODE_OFF: begin
					status_led <= 1'b0;
				end
				MODE_ON: begin
					status_led <= 1'b1;
				end
				MODE_BLINK: begin
					if (mode_changed) begin
						status_led <= 1'b0;
					end else if (blink_done) begin
						status_led <= ~status_led;
					end
				end
				default: begin
					status_led <= 1'b0;
				end
			endcase
		end
	end

	// Activity LED stays lit EXT_LEN cycles past the last ping.
	always_ff @(posedge clk) begin
		if (reset) begin
			act_led <= 1'b0;
			ext_count <= '0;
		end else if (ping) begin
			act_led <= 1'b1;
			ext_count <= '0;
		end else if (ext_count == EXT_LAST) begin
			act_led <= 1'b0;
		end else begin
			ext_count <= ext_count + 1'b1;
		end
	end

endmodule

// File: src/mode_controller.sv
module mode_controller
	import panel_ctrl_pkg::*;
(
	input  logic  clk,
	input  logic  reset,
	input  logic  press,
	output mode_t mode,
	output logic  mode_changed
);

	mode_t mode_next;

	// Fixed cycle OFF, ON, BLINK and back to OFF.
	always_comb begin
		case (mode)
			MODE_OFF: begin
				mode_next = MODE_ON;
			end
			MODE_ON: begin
				mode_next = MODE_BLINK;
			end
			MODE_BLINK: begin
				mode_next = MODE_OFF;
			end
			default: begin
				mode_next = MODE_OFF;
			end
		endcase
	end

	// One step per press, held otherwise.
	always_ff @(posedge clk) begin
		if (reset) begin
			mode <= MODE_OFF;
		end else if (press) begin
			mode <= mode_next;
		end
	end

	// High in the cycle after each step.
	always_ff @(posedge clk) begin
		if (reset) begin
			mode_changed <= 1'b0;
		end else begin
			mode_changed <= press;
		end
	end

endmodule

// File: src/panel_ctrl_pkg.sv
package panel_ctrl_pkg;

	// Mode machine states, stepped in this order by the mode button.
	typedef enum logic [1:0] {
		MODE_OFF   = 2'd0,
		MODE_ON    = 2'd1,
		MODE_BLINK = 2'd2
	} mode_t;

	// Visible panel state.
	// Status_led follows the mode and act_led is the stretched ping.
	typedef struct packed {
		mode_t mode;
		logic  status_led;
		logic  act_led;
	} panel_status_t;

endpackage

// File: src/panel_input_pkg.sv
package panel_input_pkg;

	// One conditioned button.
	// Level is the debounced state and press is high for one cycle
	// on each rising edge of that level.
	typedef struct packed {
		logic level;
		logic press;
	} button_t;

	// Both panel buttons, as the top level exposes them.
	typedef struct packed {
		button_t mode_btn;
		button_t ping_btn;
	} buttons_t;

endpackage

// File: src/panel_params.svh
`ifndef PANEL_PARAMS_SVH
`define PANEL_PARAMS_SVH

// Synchronizer stages on each raw button input.
`define SYNC_DELAY_LEN 2

// Stable synchronized cycles before the clean level follows.
`define DEBOUNCE_COUNT 12

// Clock cycles per divider tick.
`define TICK_PERIOD 4

// Ticks per half period of the blink.
`define BLINK_TICKS 3

// Cycles the activity LED stays lit after the last ping.
`define EXTEND_LEN 20

`endif

// File: src/panel_top.sv
module panel_top
	import panel_input_pkg::*;
	import panel_ctrl_pkg::*;
(
	input  logic          clk,
	input  logic          reset,
	input  logic          mode_btn_raw,
	input  logic          ping_btn_raw,
	output panel_status_t status,
	output buttons_t      buttons
);

	logic mode_changed;

	button_conditioner u_mode_cond (
		.clk    (clk),
		.reset  (reset),
		.raw    (mode_btn_raw),
		.button (buttons.mode_btn)
	);

	button_conditioner u_ping_cond (
		.clk    (clk),
		.reset  (reset),
		.raw    (ping_btn_raw),
		.button (buttons.ping_btn)
	);

	mode_controller u_mode (
		.clk          (clk),
		.reset        (reset),
		.press        (buttons.mode_btn.press),
		.mode         (status.mode),
		.mode_changed (mode_changed)
	);

	// The LED driver reads the mode back from the status port.
	led_driver u_leds (
		.clk          (clk),
		.reset        (reset),
		.mode         (status.mode),
		.mode_changed (mode_changed),
		.ping         (buttons.ping_btn.press),
		.status_led   (status.status_led),
		.act_led      (status.act_led)
	);

endmodule
